// File: src/mfifo_pkg.sv
`default_nettype none

package mfifo_pkg;

  // Sizes of the shared store
  localparam int NUM_FIFOS = 4;
  localparam int DEPTH = 8;
  localparam int DATA_W = 16;

  // Cycles from a staging load until the entry can be allocated again
  localparam int DEALLOC_DELAY = 2;

  // Vector widths
  localparam int ENTRY_W = 3;
  localparam int FIFO_ID_W = 2;
  localparam int COUNT_W = 4;

  typedef logic [ENTRY_W-1:0] entry_id_t;
  typedef logic [FIFO_ID_W-1:0] fifo_id_t;
  typedef logic [DATA_W-1:0] data_t;
  // Holds 0 to DEPTH inclusive
  typedef logic [COUNT_W-1:0] count_t;

  // Request on the push port
  typedef struct packed {
    fifo_id_t fifo_id;
    data_t    data;
  } push_req_t;

  // Data store write from the push side
  typedef struct packed {
    logic      valid;
    entry_id_t entry;
    data_t     data;
  } store_wr_t;

  // Tail append for one logical FIFO
  typedef struct packed {
    logic      valid;
    fifo_id_t  fifo_id;
    entry_id_t entry;
  } append_t;

  // Next-pointer write, old tail points at the new entry
  typedef struct packed {
    logic      valid;
    entry_id_t entry;
    entry_id_t next;
  } link_wr_t;

endpackage

`default_nettype wire

// File: src/mfifo_freelist.sv
`timescale 1ns/1ps
`default_nettype none

module mfifo_freelist (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  output logic                                                 alloc_valid,
  output mfifo_pkg::entry_id_t                                 alloc_entry,
  input  logic                                                 alloc_take,
  input  logic                 [mfifo_pkg::NUM_FIFOS-1:0]      dealloc_valid,
  input  mfifo_pkg::entry_id_t [mfifo_pkg::NUM_FIFOS-1:0]      dealloc_entry
);

  // One bit per store entry that a FIFO owns
  logic [mfifo_pkg::DEPTH-1:0] busy;
  logic [mfifo_pkg::DEPTH-1:0] busy_next;
  logic [mfifo_pkg::DEPTH-1:0] alloc_mask;
  logic [mfifo_pkg::DEPTH-1:0] free_mask;
  logic                        alloc_in_pipe;

  // Delay pipe for freed entries with one lane per pop port
  logic [mfifo_pkg::DEALLOC_DELAY-1:0][mfifo_pkg::NUM_FIFOS-1:0] pipe_valid;
  mfifo_pkg::entry_id_t [mfifo_pkg::DEALLOC_DELAY-1:0][mfifo_pkg::NUM_FIFOS-1:0] pipe_entry;

  // Offer whenever any bit is clear
  assign alloc_valid = ~&busy;

  // Lowest free index wins
  always_comb begin
    alloc_entry = '0;
    for (int i = mfifo_pkg::DEPTH - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        alloc_entry = mfifo_pkg::entry_id_t'(i);
      end
    end
  end

  always_comb begin
    alloc_mask = '0;
    free_mask  = '0;
    if (alloc_take && alloc_valid) begin
      alloc_mask[alloc_entry] = 1'b1;
    end
    // Last pipe stage releases its entries
    for (int f = 0; f < mfifo_pkg::NUM_FIFOS; f++) begin
      if (pipe_valid[mfifo_pkg::DEALLOC_DELAY-1][f]) begin
        free_mask[pipe_entry[mfifo_pkg::DEALLOC_DELAY-1][f]] = 1'b1;
      end
    end
    busy_next = (busy | alloc_mask) & ~free_mask;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy       <= '0;
      pipe_valid <= '0;
    end else begin
      busy          <= busy_next;
      pipe_valid[0] <= dealloc_valid;
      for (int s = 1; s < mfifo_pkg::DEALLOC_DELAY; s++) begin
        pipe_valid[s] <= pipe_valid[s-1];
      end
    end
  end

  // Entry ids ride along and are qualified by pipe_valid
  always_ff @(posedge clk) begin
    pipe_entry[0] <= dealloc_entry;
    for (int s = 1; s < mfifo_pkg::DEALLOC_DELAY; s++) begin
      pipe_entry[s] <= pipe_entry[s-1];
    end
  end

  // Entry on offer that still waits somewhere in the release pipe
  always_comb begin
    alloc_in_pipe = 1'b0;
    for (int s = 0; s < mfifo_pkg::DEALLOC_DELAY; s++) begin
      for (int f = 0; f < mfifo_pkg::NUM_FIFOS; f++) begin
        if (pipe_valid[s][f] && (pipe_entry[s][f] == alloc_entry)) begin
          alloc_in_pipe = 1'b1;
        end
      end
    end
  end

  // A released entry must still be owned
  for (genvar f = 0; f < mfifo_pkg::NUM_FIFOS; f++) begin : gen_free_chk
    free_of_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
      pipe_valid[mfifo_pkg::DEALLOC_DELAY-1][f]
        |-> busy[pipe_entry[mfifo_pkg::DEALLOC_DELAY-1][f]]);
  end

  // Push side only takes an offered entry with no release pending on it
  alloc_free_a: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_take |-> (alloc_valid && !alloc_in_pipe));

endmodule

`default_nettype wire

// File: src/mfifo_push_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mfifo_push_ctrl (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            push_valid,
  input  mfifo_pkg::push_req_t                            push_req,
  output logic                                            push_ready,
  output logic                                            push_full,
  output mfifo_pkg::store_wr_t                            store_wr,
  output mfifo_pkg::append_t                              append,
  input  logic                 [mfifo_pkg::NUM_FIFOS-1:0] dealloc_valid,
  input  mfifo_pkg::entry_id_t [mfifo_pkg::NUM_FIFOS-1:0] dealloc_entry
);

  logic                 alloc_valid;
  mfifo_pkg::entry_id_t alloc_entry;
  logic                 accept;

  mfifo_freelist u_freelist (
    .clk           (clk),
    .rst_n         (rst_n),
    .alloc_valid   (alloc_valid),
    .alloc_entry   (alloc_entry),
    .alloc_take    (accept),
    .dealloc_valid (dealloc_valid),
    .dealloc_entry (dealloc_entry)
  );

  // Ready only reflects free space, never push_valid
  assign push_ready = alloc_valid;
  assign push_full  = !alloc_valid;
  assign accept     = push_valid && push_ready;

  // Data goes into the granted entry
  always_comb begin
    store_wr.valid = accept;
    store_wr.entry = alloc_entry;
    store_wr.data  = push_req.data;
  end

  // Same entry is linked onto the chosen FIFO
  always_comb begin
    append.valid   = accept;
    append.fifo_id = push_req.fifo_id;
    append.entry   = alloc_entry;
  end

  // Routing needs a known FIFO id
  fifo_id_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    push_valid |-> !$isunknown(push_req.fifo_id));

  // Held request stays put until accepted
  push_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    (push_valid && !push_ready) |=> (push_valid && $stable(push_req)));

endmodule

`default_nettype wire

// File: src/mfifo_link_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mfifo_link_ctrl #(
  parameter int FIFO_INDEX = 0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mfifo_pkg::append_t   append,
  input  logic                 advance,
  input  mfifo_pkg::entry_id_t next_of_head,
  output logic                 head_valid,
  output mfifo_pkg::entry_id_t head,
  output mfifo_pkg::link_wr_t  link_wr
);

  mfifo_pkg::entry_id_t tail;
  mfifo_pkg::count_t    count;
  mfifo_pkg::count_t    count_next;
  logic                 my_append;

  // Only appends aimed at this FIFO
  assign my_append = append.valid &&
                     (append.fifo_id == mfifo_pkg::fifo_id_t'(FIFO_INDEX));

  assign head_valid = (count != '0);

  // Old tail points at the new entry
  // an empty list has no tail to link
  always_comb begin
    link_wr.valid = my_append && (count != '0);
    link_wr.entry = tail;
    link_wr.next  = append.entry;
  end

  always_comb begin
    count_next = count;
    if (my_append && !advance) begin
      count_next = count + mfifo_pkg::count_t'(1);
    end else if (!my_append && advance) begin
      count_next = count - mfifo_pkg::count_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

  // Pointers only mean something while count is nonzero
  always_ff @(posedge clk) begin
    if (my_append) begin
      tail <= append.entry;
    end
    if (advance) begin
      // Last entry leaving, so the appended one (if any) becomes head
      if (count == mfifo_pkg::count_t'(1)) begin
        head <= append.entry;
      end else begin
        head <= next_of_head;
      end
    end else if (my_append && (count == '0)) begin
      head <= append.entry;
    end
  end

  // Pop side only advances a list that holds something
  advance_nonempty_a: assert property (@(posedge clk) disable iff (!rst_n)
    advance |-> (count != '0));

  // Free list keeps total occupancy within the store
  count_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
    count <= mfifo_pkg::count_t'(mfifo_pkg::DEPTH));

endmodule

`default_nettype wire

// File: src/mfifo_storage.sv
`timescale 1ns/1ps
`default_nettype none

module mfifo_storage (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  mfifo_pkg::store_wr_t                            store_wr,
  input  mfifo_pkg::link_wr_t  [mfifo_pkg::NUM_FIFOS-1:0] link_wr,
  input  mfifo_pkg::entry_id_t [mfifo_pkg::NUM_FIFOS-1:0] rd_entry,
  output mfifo_pkg::data_t     [mfifo_pkg::NUM_FIFOS-1:0] rd_data,
  output mfifo_pkg::entry_id_t [mfifo_pkg::NUM_FIFOS-1:0] rd_next
);

  // Flop arrays, payload and links
  mfifo_pkg::data_t     data_mem [mfifo_pkg::DEPTH];
  mfifo_pkg::entry_id_t next_mem [mfifo_pkg::DEPTH];
  logic                 link_clash;

  always_ff @(posedge clk) begin
    if (store_wr.valid) begin
      data_mem[store_wr.entry] <= store_wr.data;
    end
  end

  // One next-pointer write port per FIFO
  always_ff @(posedge clk) begin
    for (int f = 0; f < mfifo_pkg::NUM_FIFOS; f++) begin
      if (link_wr[f].valid) begin
        next_mem[link_wr[f].entry] <= link_wr[f].next;
      end
    end
  end

  // Combinational read pair per FIFO head
  always_comb begin
    for (int f = 0; f < mfifo_pkg::NUM_FIFOS; f++) begin
      rd_data[f] = data_mem[rd_entry[f]];
      rd_next[f] = next_mem[rd_entry[f]];
    end
  end

  // Any two link ports hitting one entry
  always_comb begin
    link_clash = 1'b0;
    for (int i = 0; i < mfifo_pkg::NUM_FIFOS; i++) begin
      for (int j = i + 1; j < mfifo_pkg::NUM_FIFOS; j++) begin
        if (link_wr[i].valid && link_wr[j].valid &&
            (link_wr[i].entry == link_wr[j].entry)) begin
          link_clash = 1'b1;
        end
      end
    end
  end

  // Tails of different lists never share an entry
  link_unique_a: assert property (@(posedge clk) disable iff (!rst_n)
    !link_clash);

endmodule

`default_nettype wire

// File: src/mfifo_pop_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mfifo_pop_ctrl (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                 [mfifo_pkg::NUM_FIFOS-1:0] head_valid,
  input  mfifo_pkg::entry_id_t [mfifo_pkg::NUM_FIFOS-1:0] head,
  input  mfifo_pkg::data_t     [mfifo_pkg::NUM_FIFOS-1:0] rd_data,
  output logic                 [mfifo_pkg::NUM_FIFOS-1:0] advance,
  output logic                 [mfifo_pkg::NUM_FIFOS-1:0] pop_valid,
  output mfifo_pkg::data_t     [mfifo_pkg::NUM_FIFOS-1:0] pop_data,
  input  logic                 [mfifo_pkg::NUM_FIFOS-1:0] pop_ready,
  output logic                 [mfifo_pkg::NUM_FIFOS-1:0] dealloc_valid,
  output mfifo_pkg::entry_id_t [mfifo_pkg::NUM_FIFOS-1:0] dealloc_entry
);

  // Staging register per FIFO
  logic             [mfifo_pkg::NUM_FIFOS-1:0] stage_valid;
  mfifo_pkg::data_t [mfifo_pkg::NUM_FIFOS-1:0] stage_data;
  logic             [mfifo_pkg::NUM_FIFOS-1:0] pop_fire;
  logic             [mfifo_pkg::NUM_FIFOS-1:0] load;

  assign pop_fire = stage_valid & pop_ready;

  // With pop_ready high staging is either empty or popped this cycle
  // Low pop_ready freezes the list so entries stay in the shared store
  assign load = head_valid & pop_ready;

  // Head moves on as its entry lands in staging
  assign advance = load;

  // Staging now owns the payload, so the entry goes back
  assign dealloc_valid = load;
  assign dealloc_entry = head;

  assign pop_valid = stage_valid;
  assign pop_data  = stage_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_valid <= '0;
    end else begin
      for (int f = 0; f < mfifo_pkg::NUM_FIFOS; f++) begin
        if (load[f]) begin
          stage_valid[f] <= 1'b1;
        end else if (pop_fire[f]) begin
          stage_valid[f] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int f = 0; f < mfifo_pkg::NUM_FIFOS; f++) begin
      if (load[f]) begin
        stage_data[f] <= rd_data[f];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/mfifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module mfifo_top (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        push_valid,
  input  mfifo_pkg::push_req_t                        push_req,
  output logic                                        push_ready,
  output logic                                        push_full,
  output logic             [mfifo_pkg::NUM_FIFOS-1:0] pop_valid,
  output mfifo_pkg::data_t [mfifo_pkg::NUM_FIFOS-1:0] pop_data,
  input  logic             [mfifo_pkg::NUM_FIFOS-1:0] pop_ready
);

  mfifo_pkg::store_wr_t                            store_wr;
  mfifo_pkg::append_t                              append;
  mfifo_pkg::link_wr_t  [mfifo_pkg::NUM_FIFOS-1:0] link_wr;
  logic                 [mfifo_pkg::NUM_FIFOS-1:0] head_valid;
  mfifo_pkg::entry_id_t [mfifo_pkg::NUM_FIFOS-1:0] head;
  mfifo_pkg::data_t     [mfifo_pkg::NUM_FIFOS-1:0] rd_data;
  mfifo_pkg::entry_id_t [mfifo_pkg::NUM_FIFOS-1:0] rd_next;
  logic                 [mfifo_pkg::NUM_FIFOS-1:0] advance;
  logic                 [mfifo_pkg::NUM_FIFOS-1:0] dealloc_valid;
  mfifo_pkg::entry_id_t [mfifo_pkg::NUM_FIFOS-1:0] dealloc_entry;

  // Input side, owns the free list
  mfifo_push_ctrl u_push_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_valid    (push_valid),
    .push_req      (push_req),
    .push_ready    (push_ready),
    .push_full     (push_full),
    .store_wr      (store_wr),
    .append        (append),
    .dealloc_valid (dealloc_valid),
    .dealloc_entry (dealloc_entry)
  );

  // One list per logical FIFO
  for (genvar f = 0; f < mfifo_pkg::NUM_FIFOS; f++) begin : gen_link
    mfifo_link_ctrl #(
      .FIFO_INDEX (f)
    ) u_link_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .append       (append),
      .advance      (advance[f]),
      .next_of_head (rd_next[f]),
      .head_valid   (head_valid[f]),
      .head         (head[f]),
      .link_wr      (link_wr[f])
    );
  end

  // Reads are addressed by each list head
  mfifo_storage u_storage (
    .clk      (clk),
    .rst_n    (rst_n),
    .store_wr (store_wr),
    .link_wr  (link_wr),
    .rd_entry (head),
    .rd_data  (rd_data),
    .rd_next  (rd_next)
  );

  mfifo_pop_ctrl u_pop_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .head_valid    (head_valid),
    .head          (head),
    .rd_data       (rd_data),
    .advance       (advance),
    .pop_valid     (pop_valid),
    .pop_data      (pop_data),
    .pop_ready     (pop_ready),
    .dealloc_valid (dealloc_valid),
    .dealloc_entry (dealloc_entry)
  );

endmodule

`default_nettype wire

// File: tb/mfifo_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mfifo_checker (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        push_ready,
  input  logic                                        push_full,
  input  logic             [mfifo_pkg::NUM_FIFOS-1:0] pop_valid,
  input  mfifo_pkg::data_t [mfifo_pkg::NUM_FIFOS-1:0] pop_data,
  input  logic             [mfifo_pkg::NUM_FIFOS-1:0] pop_ready
);

  localparam int QUEUE_LEN = 64;

  // Expected values per FIFO, ring buffers with free-running indices
  mfifo_pkg::data_t exp_mem [mfifo_pkg::NUM_FIFOS][QUEUE_LEN];
  int               exp_wr  [mfifo_pkg::NUM_FIFOS];
  int               exp_rd  [mfifo_pkg::NUM_FIFOS];

  // Totals for the closing line
  int error_count;
  int test_errors;
  int tests_passed;
  int tests_failed;

  initial begin
    for (int f = 0; f < mfifo_pkg::NUM_FIFOS; f++) begin
      exp_wr[f] = 0;
      exp_rd[f] = 0;
    end
    error_count  = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
  end

  task automatic record_error();
    error_count++;
    test_errors++;
  endtask

  // Failure that is not a wrong value
  task automatic plain_fail(input string msg);
    $display("%s", msg);
    record_error();
  endtask

  task automatic add_expect(input int f, input mfifo_pkg::data_t d);
    if (exp_wr[f] - exp_rd[f] >= QUEUE_LEN) begin
      plain_fail($sformatf("Too many outstanding values queued for FIFO %0d", f));
    end else begin
      exp_mem[f][exp_wr[f] % QUEUE_LEN] = d;
      exp_wr[f]++;
    end
  endtask

  // Values still waiting to come out, all FIFOs together
  function automatic int pending();
    int total;
    total = 0;
    for (int f = 0; f < mfifo_pkg::NUM_FIFOS; f++) begin
      total += exp_wr[f] - exp_rd[f];
    end
    return total;
  endfunction

  task automatic check_pop(input int f, input mfifo_pkg::data_t got);
    mfifo_pkg::data_t want;
    if (exp_rd[f] == exp_wr[f]) begin
      $display("** Error at %0t: FIFO %0d popped %h with nothing expected", $time, f, got);
      record_error();
    end else begin
      want = exp_mem[f][exp_rd[f] % QUEUE_LEN];
      exp_rd[f]++;
      if (got !== want) begin
        $display("** Error at %0t: FIFO %0d popped %h, expected %h", $time, f, got, want);
        record_error();
      end
    end
  endtask

  // Every pop handshake is held against the head of its queue
  always @(posedge clk) begin
    if (rst_n) begin
      for (int f = 0; f < mfifo_pkg::NUM_FIFOS; f++) begin
        if (pop_valid[f] && pop_ready[f]) begin
          check_pop(f, pop_data[f]);
        end
      end
    end
  end

  // Full flag and ready are complements of each other
  task automatic check_full(input logic exp_full);
    if (push_full !== exp_full || push_ready !== !exp_full) begin
      $display("** Error at %0t: push_full %b push_ready %b, expected push_full %b",
               $time, push_full, push_ready, exp_full);
      record_error();
    end
  endtask

  task automatic close_test(input int id);
    for (int f = 0; f < mfifo_pkg::NUM_FIFOS; f++) begin
      if (exp_wr[f] != exp_rd[f]) begin
        plain_fail($sformatf("FIFO %0d still expects %0d values at the end of test %0d",
                             f, exp_wr[f] - exp_rd[f], id));
      end
    end
    // Nothing may sit in staging once the test is drained
    if (pop_valid !== '0) begin
      $display("** Error at %0t: pop_valid %b at end of test %0d, expected all low",
               $time, pop_valid, id);
      record_error();
    end
    if (test_errors == 0) begin
      tests_passed++;
      $display("Test %0d passed", id);
    end else begin
      tests_failed++;
      $display("Test %0d failed with %0d errors", id, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic summary();
    $display("Tests passed %0d, tests failed %0d, errors %0d",
             tests_passed, tests_failed, error_count);
  endtask

endmodule

`default_nettype wire

// File: tb/mfifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mfifo_tb;

  localparam int    CLK_PERIOD    = 8;
  localparam int    RESET_CYCLES  = 5;
  localparam int    PUSH_TIMEOUT  = 200;
  localparam int    DRAIN_TIMEOUT = 1000;
  localparam string INPUT_FILE    = "tb/mfifo_input.txt";

  logic                                        clk;
  logic                                        rst_n;
  logic                                        push_valid;
  mfifo_pkg::push_req_t                        push_req;
  logic                                        push_ready;
  logic                                        push_full;
  logic             [mfifo_pkg::NUM_FIFOS-1:0] pop_valid;
  mfifo_pkg::data_t [mfifo_pkg::NUM_FIFOS-1:0] pop_data;
  logic             [mfifo_pkg::NUM_FIFOS-1:0] pop_ready;

  // Pop enable per FIFO, random gaps on top when gap_mode is set
  logic [mfifo_pkg::NUM_FIFOS-1:0] pop_mask;
  logic                            gap_mode;
  logic                            aborted;

  mfifo_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_req   (push_req),
    .push_ready (push_ready),
    .push_full  (push_full),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .pop_ready  (pop_ready)
  );

  mfifo_checker chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_ready (push_ready),
    .push_full  (push_full),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .pop_ready  (pop_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // One clock, then new pop_ready just after the edge
  task automatic tick();
    logic [mfifo_pkg::NUM_FIFOS-1:0] gaps;
    @(posedge clk);
    #1;
    gaps = '1;
    if (gap_mode) begin
      for (int f = 0; f < mfifo_pkg::NUM_FIFOS; f++) begin
        gaps[f] = ($urandom % 4) != 0;
      end
    end
    pop_ready = pop_mask & gaps;
  endtask

  // Hold the request until an edge with push_ready high
  task automatic push_entry(input int f, input mfifo_pkg::data_t d);
    int n;
    n = 0;
    push_valid       = 1'b1;
    push_req.fifo_id = mfifo_pkg::fifo_id_t'(f);
    push_req.data    = d;
    while (!push_ready && n < PUSH_TIMEOUT) begin
      tick();
      n++;
    end
    if (!push_ready) begin
      chk.plain_fail($sformatf("Push of %h to FIFO %0d never saw push_ready", d, f));
      aborted = 1'b1;
    end else begin
      tick();
      push_valid = 1'b0;
    end
  endtask

  task automatic drain_and_close(input int id);
    int n;
    n = 0;
    while (chk.pending() != 0 && n < DRAIN_TIMEOUT) begin
      tick();
      n++;
    end
    if (chk.pending() != 0) begin
      chk.plain_fail($sformatf("Test %0d timed out waiting for the FIFOs to drain", id));
      aborted = 1'b1;
    end
    chk.close_test(id);
  endtask

  task automatic run_command(input byte cmd, input int a, input int b);
    case (cmd)
      "P": push_entry(a, mfifo_pkg::data_t'(b));
      "E": chk.add_expect(a, mfifo_pkg::data_t'(b));
      "M": begin
        pop_mask = a[mfifo_pkg::NUM_FIFOS-1:0];
        gap_mode = b[0];
      end
      "W": repeat (a) tick();
      "F": chk.check_full(a[0]);
      "T": drain_and_close(a);
      default: begin
        $display("Unknown command %c in %s", cmd, INPUT_FILE);
        aborted = 1'b1;
      end
    endcase
  endtask

  initial begin
    int    fd;
    int    code;
    string line;
    byte   cmd;
    int    a;
    int    b;
    rst_n      = 1'b0;
    push_valid = 1'b0;
    push_req   = '0;
    pop_ready  = '0;
    pop_mask   = '0;
    gap_mode   = 1'b0;
    aborted    = 1'b0;
    void'($urandom(32'hb3cb));
    repeat (RESET_CYCLES) tick();
    rst_n = 1'b1;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("Could not open %s for reading", INPUT_FILE);
      aborted = 1'b1;
    end
    // Comment and blank lines are skipped
    while (!aborted && fd != 0 && !$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        a    = 0;
        b    = 0;
        code = $sscanf(line, "%c %h %h", cmd, a, b);
        run_command(cmd, a, b);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    chk.summary();
    if (!aborted && chk.error_count == 0 && chk.tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/mfifo_input.txt
# Command letter then hex fields a and b. P and E push or expect data b on FIFO a
# M sets pop mask a with random gaps when b is 1. W waits a cycles, F checks push_full, T ends test a
M f 0
E 0 1000
P 0 1000
E 1 1100
P 1 1100
E 0 1001
P 0 1001
E 2 1200
P 2 1200
E 3 1300
P 3 1300
E 1 1101
P 1 1101
E 2 1201
P 2 1201
E 3 1301
P 3 1301
T 1 0
M b 0
E 2 2200
P 2 2200
E 0 2000
P 0 2000
E 2 2201
P 2 2201
E 1 2100
P 1 2100
E 3 2300
P 3 2300
E 2 2202
P 2 2202
W 10 0
M f 0
T 2 0
M 0 0
W 4 0
P 0 3000
P 1 3100
P 1 3101
P 1 3102
P 2 3200
P 2 3201
P 3 3300
F 0 0
P 3 3301
F 1 0
T 3 0
E 0 3000
E 0 4000
E 1 3100
E 1 3101
E 1 3102
E 2 3200
E 2 3201
E 3 3300
E 3 3301
M 1 0
P 0 4000
M f 0
T 4 0
M f 1
E 0 5000
P 0 5000
E 1 5100
P 1 5100
E 1 5101
P 1 5101
E 3 5300
P 3 5300
E 0 5001
P 0 5001
E 2 5200
P 2 5200
E 3 5301
P 3 5301
E 0 5002
P 0 5002
E 2 5201
P 2 5201
E 1 5102
P 1 5102
T 5 0

// File: list.f
src/mfifo_pkg.sv
src/mfifo_freelist.sv
src/mfifo_push_ctrl.sv
src/mfifo_link_ctrl.sv
src/mfifo_storage.sv
src/mfifo_pop_ctrl.sv
src/mfifo_top.sv
tb/mfifo_checker.sv
tb/mfifo_tb.sv

// File: Bender.yml
package:
  name: mfifo

sources:
  # Design, package first
  - src/mfifo_pkg.sv
  - src/mfifo_freelist.sv
  - src/mfifo_push_ctrl.sv
  - src/mfifo_link_ctrl.sv
  - src/mfifo_storage.sv
  - src/mfifo_pop_ctrl.sv
  - src/mfifo_top.sv

  # Testbench
  - target: simulation
    files:
      - tb/mfifo_checker.sv
      - tb/mfifo_tb.sv
